// File: common/periph_consts.svh
/*
 * Peripheral subsystem constants.
 * Bus widths, the device address map, register word offsets,
 * pin widths and the PWM channel count.
 */
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// Host bus widths.
`define PERIPH_ADDR_W 12
`define PERIPH_DATA_W 32
`define PERIPH_BE_W   4

// Word offset inside a device region, address bits 7..2.
`define PERIPH_OFF_W 6

// Device select field of the byte address.
`define PERIPH_DEV_MSB 9
`define PERIPH_DEV_LSB 8

// Device region bases.
`define GPIO_BASE  (`PERIPH_ADDR_W'('h000))
`define PWM_BASE   (`PERIPH_ADDR_W'('h100))
`define TIMER_BASE (`PERIPH_ADDR_W'('h200))

// Register word offsets.
`define GPIO_OUT_OFF    (`PERIPH_OFF_W'(0))
`define GPIO_IN_OFF     (`PERIPH_OFF_W'(1))
`define TIMER_MTIME_OFF (`PERIPH_OFF_W'(0))
`define TIMER_CMP_OFF   (`PERIPH_OFF_W'(1))
`define TIMER_CTRL_OFF  (`PERIPH_OFF_W'(2))

// Pins and PWM.
`define GPI_W     8
`define GPO_W     8
`define PWM_CH    4
`define PWM_CTR_W 8

`endif

// File: common/periph_pkg.sv
/*
 * Peripheral subsystem package.
 * Sequencer state and decoded device types, plus the byte-lane
 * merge shared by the register blocks.
 */
package periph_pkg;

  `include "periph_consts.svh"

  // Access sequencer states.
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_ACCESS = 2'd1,
    ST_RESP   = 2'd2
  } state_e;

  // Decoded target of a host access.
  typedef enum logic [1:0] {
    DEV_GPIO  = 2'd0,
    DEV_PWM   = 2'd1,
    DEV_TIMER = 2'd2,
    DEV_NONE  = 2'd3
  } device_e;

  // Replace the byte lanes of old_v selected by be with new_v.
  function automatic logic [`PERIPH_DATA_W-1:0] apply_be(
    input logic [`PERIPH_DATA_W-1:0] old_v,
    input logic [`PERIPH_DATA_W-1:0] new_v,
    input logic [`PERIPH_BE_W-1:0]   be
  );
    logic [`PERIPH_DATA_W-1:0] res;
    res = old_v;
    for (int b = 0; b < `PERIPH_BE_W; b++) begin
      if (be[b]) res[b*8 +: 8] = new_v[b*8 +: 8];
    end
    return res;
  endfunction

endpackage

// File: source/bus_ctrl.sv
/*
 * Access sequencer for the peripheral bus.
 * Grants one host request at a time, decodes the target device,
 * strobes it for one cycle and returns a single response beat.
 */
`timescale 1ns/1ps

`include "periph_consts.svh"

module bus_ctrl (
  input  logic                      clk_sys_i,
  input  logic                      rst_n_i,

  input  logic                      req_i,
  input  logic                      we_i,
  input  logic [`PERIPH_ADDR_W-1:0] addr_i,
  input  logic [`PERIPH_BE_W-1:0]   be_i,
  input  logic [`PERIPH_DATA_W-1:0] wdata_i,
  output logic                      gnt_o,
  output logic                      rvalid_o,
  output logic [`PERIPH_DATA_W-1:0] rdata_o,
  output logic                      err_o,

  output logic                      gpio_req_o,
  output logic                      pwm_req_o,
  output logic                      timer_req_o,
  output logic                      dev_we_o,
  output logic [`PERIPH_OFF_W-1:0]  dev_off_o,
  output logic [`PERIPH_BE_W-1:0]   dev_be_o,
  output logic [`PERIPH_DATA_W-1:0] dev_wdata_o,
  input  logic [`PERIPH_DATA_W-1:0] gpio_rdata_i,
  input  logic [`PERIPH_DATA_W-1:0] pwm_rdata_i,
  input  logic [`PERIPH_DATA_W-1:0] timer_rdata_i
);
  import periph_pkg::*;

  localparam logic [`PERIPH_ADDR_W-1:0] GpioBase  = `GPIO_BASE;
  localparam logic [`PERIPH_ADDR_W-1:0] PwmBase   = `PWM_BASE;
  localparam logic [`PERIPH_ADDR_W-1:0] TimerBase = `TIMER_BASE;

  state_e  state_q, state_d;
  device_e dev_d, dev_q;
  logic    accept;

  logic                      we_q;
  logic [`PERIPH_OFF_W-1:0]  off_q;
  logic [`PERIPH_BE_W-1:0]   be_q;
  logic [`PERIPH_DATA_W-1:0] wdata_q;

  ////////////////////////////////////////
  // Address decode and sequencing
  ////////////////////////////////////////

  always_comb begin
    dev_d = DEV_NONE;
    if (!(|addr_i[`PERIPH_ADDR_W-1:`PERIPH_DEV_MSB+1])) begin
      case (addr_i[`PERIPH_DEV_MSB:`PERIPH_DEV_LSB])
        GpioBase[`PERIPH_DEV_MSB:`PERIPH_DEV_LSB]:  dev_d = DEV_GPIO;
        PwmBase[`PERIPH_DEV_MSB:`PERIPH_DEV_LSB]:   dev_d = DEV_PWM;
        TimerBase[`PERIPH_DEV_MSB:`PERIPH_DEV_LSB]: dev_d = DEV_TIMER;
        default:                                    dev_d = DEV_NONE;
      endcase
    end
  end

  assign gnt_o  = (state_q == ST_IDLE);
  assign accept = req_i & gnt_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:   if (req_i) state_d = ST_ACCESS;
      ST_ACCESS: state_d = ST_RESP;
      ST_RESP:   state_d = ST_IDLE;
      default:   state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      dev_q   <= DEV_NONE;
    end else begin
      state_q <= state_d;
      if (accept) dev_q <= dev_d;
    end
  end

  // Request payload, captured at acceptance.
  always_ff @(posedge clk_sys_i) begin
    if (accept) begin
      we_q    <= we_i;
      off_q   <= addr_i[`PERIPH_OFF_W+1:2];
      be_q    <= be_i;
      wdata_q <= wdata_i;
    end
  end

  ////////////////////////////////////////
  // Device strobes and response
  ////////////////////////////////////////

  assign gpio_req_o  = (state_q == ST_ACCESS) && (dev_q == DEV_GPIO);
  assign pwm_req_o   = (state_q == ST_ACCESS) && (dev_q == DEV_PWM);
  assign timer_req_o = (state_q == ST_ACCESS) && (dev_q == DEV_TIMER);
  assign dev_we_o    = we_q;
  assign dev_off_o   = off_q;
  assign dev_be_o    = be_q;
  assign dev_wdata_o = wdata_q;

  assign rvalid_o = (state_q == ST_RESP);
  assign err_o    = (state_q == ST_RESP) && (dev_q == DEV_NONE);

  // Writes and unmapped accesses return zero.
  always_comb begin
    rdata_o = '0;
    if (rvalid_o && !we_q) begin
      case (dev_q)
        DEV_GPIO:  rdata_o = gpio_rdata_i;
        DEV_PWM:   rdata_o = pwm_rdata_i;
        DEV_TIMER: rdata_o = timer_rdata_i;
        default:   rdata_o = '0;
      endcase
    end
  end

  // Only one device is addressed per access.
  a_one_strobe: assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
    $onehot0({gpio_req_o, pwm_req_o, timer_req_o}));

  a_no_gnt_in_resp: assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
    !(rvalid_o && gnt_o));

endmodule

// File: source/gpio.sv
/*
 * GPIO block.
 * Byte-writable output register and a two-flop synchronized
 * input register, both readable over the device port.
 */
`timescale 1ns/1ps

`include "periph_consts.svh"

module gpio (
  input  logic                      clk_sys_i,
  input  logic                      rst_n_i,
  input  logic                      req_i,
  input  logic                      we_i,
  input  logic [`PERIPH_OFF_W-1:0]  off_i,
  input  logic [`PERIPH_BE_W-1:0]   be_i,
  input  logic [`PERIPH_DATA_W-1:0] wdata_i,
  output logic [`PERIPH_DATA_W-1:0] rdata_o,
  input  logic [`GPI_W-1:0]         gp_i,
  output logic [`GPO_W-1:0]         gp_o
);
  import periph_pkg::*;

  logic [`GPI_W-1:0]         gpi_meta_q;
  logic [`GPI_W-1:0]         gpi_sync_q;
  logic [`PERIPH_DATA_W-1:0] gpo_merged;

  assign gpo_merged = apply_be(`PERIPH_DATA_W'(gp_o), wdata_i, be_i);

  // Output register and input synchronizer.
  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      gp_o       <= '0;
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
    end else begin
      gpi_meta_q <= gp_i;
      gpi_sync_q <= gpi_meta_q;
      if (req_i && we_i && (off_i == `GPIO_OUT_OFF)) begin
        gp_o <= gpo_merged[`GPO_W-1:0];
      end
    end
  end

  // Registered read.
  always_ff @(posedge clk_sys_i) begin
    if (req_i && !we_i) begin
      case (off_i)
        `GPIO_OUT_OFF: rdata_o <= `PERIPH_DATA_W'(gp_o);
        `GPIO_IN_OFF:  rdata_o <= `PERIPH_DATA_W'(gpi_sync_q);
        default:       rdata_o <= '0;
      endcase
    end
  end

endmodule

// File: timer/periph_timer.sv
/*
 * Machine timer.
 * Free-running 64-bit style mtime counter cut to the bus width,
 * with a compare register, an enable bit and a level interrupt
 * raised while mtime has reached mtimecmp.
 */
`timescale 1ns/1ps

`include "periph_consts.svh"

module periph_timer (
  input  logic                      clk_sys_i,
  input  logic                      rst_n_i,
  input  logic                      req_i,
  input  logic                      we_i,
  input  logic [`PERIPH_OFF_W-1:0]  off_i,
  input  logic [`PERIPH_BE_W-1:0]   be_i,
  input  logic [`PERIPH_DATA_W-1:0] wdata_i,
  output logic [`PERIPH_DATA_W-1:0] rdata_o,
  output logic                      irq_o
);
  import periph_pkg::*;

  logic [`PERIPH_DATA_W-1:0] mtime_q, mtime_d;
  logic [`PERIPH_DATA_W-1:0] cmp_q, cmp_d;
  logic                      en_q, en_d;
  logic                      wr;

  assign wr = req_i & we_i;

  ////////////////////////////////////////
  // Next-state logic
  ////////////////////////////////////////

  always_comb begin
    mtime_d = en_q ? mtime_q + 1'b1 : mtime_q;
    cmp_d   = cmp_q;
    en_d    = en_q;
    if (wr) begin
      case (off_i)
        // Write wins over the increment.
        `TIMER_MTIME_OFF: mtime_d = apply_be(mtime_q, wdata_i, be_i);
        `TIMER_CMP_OFF:   cmp_d   = apply_be(cmp_q, wdata_i, be_i);
        `TIMER_CTRL_OFF:  if (be_i[0]) en_d = wdata_i[0];
        default: ;
      endcase
    end
  end

  // Interrupt uses next values so it tracks the enable exactly.
  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      mtime_q <= '0;
      cmp_q   <= '1;
      en_q    <= 1'b0;
      irq_o   <= 1'b0;
    end else begin
      mtime_q <= mtime_d;
      cmp_q   <= cmp_d;
      en_q    <= en_d;
      irq_o   <= en_d && (mtime_d >= cmp_d);
    end
  end

  ////////////////////////////////////////
  // Register read
  ////////////////////////////////////////

  always_ff @(posedge clk_sys_i) begin
    if (req_i && !we_i) begin
      case (off_i)
        `TIMER_MTIME_OFF: rdata_o <= mtime_q;
        `TIMER_CMP_OFF:   rdata_o <= cmp_q;
        `TIMER_CTRL_OFF:  rdata_o <= `PERIPH_DATA_W'(en_q);
        default:          rdata_o <= '0;
      endcase
    end
  end

  a_irq_needs_en: assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
    irq_o |-> en_q);

endmodule

// File: pwm/pwm_bank.sv
/*
 * PWM channel bank.
 * One 8-bit duty register per channel against a shared free-running
 * phase counter; a channel is high while phase < duty.
 */
`timescale 1ns/1ps

`include "periph_consts.svh"

module pwm_bank (
  input  logic                      clk_sys_i,
  input  logic                      rst_n_i,
  input  logic                      req_i,
  input  logic                      we_i,
  input  logic [`PERIPH_OFF_W-1:0]  off_i,
  input  logic [`PERIPH_BE_W-1:0]   be_i,
  input  logic [`PERIPH_DATA_W-1:0] wdata_i,
  output logic [`PERIPH_DATA_W-1:0] rdata_o,
  output logic [`PWM_CH-1:0]        pwm_o
);

  logic [`PWM_CTR_W-1:0] phase_q;
  logic [`PWM_CTR_W-1:0] duty_q [`PWM_CH];

  // Phase counter, duty registers and output compare.
  always_ff @(posedge clk_sys_i) begin
    if (!rst_n_i) begin
      phase_q <= '0;
      pwm_o   <= '0;
      for (int i = 0; i < `PWM_CH; i++) begin
        duty_q[i] <= '0;
      end
    end else begin
      phase_q <= phase_q + 1'b1;
      for (int i = 0; i < `PWM_CH; i++) begin
        pwm_o[i] <= (phase_q < duty_q[i]);
        // Duty lives in byte lane 0.
        if (req_i && we_i && be_i[0] && (off_i == `PERIPH_OFF_W'(i))) begin
          duty_q[i] <= wdata_i[`PWM_CTR_W-1:0];
        end
      end
    end
  end

  ////////////////////////////////////////
  // Register read
  ////////////////////////////////////////

  // Offsets past the last channel read zero.
  always_ff @(posedge clk_sys_i) begin
    if (req_i && !we_i) begin
      rdata_o <= '0;
      for (int i = 0; i < `PWM_CH; i++) begin
        if (off_i == `PERIPH_OFF_W'(i)) begin
          rdata_o <= `PERIPH_DATA_W'(duty_q[i]);
        end
      end
    end
  end

endmodule

// File: source/sonata_periph.sv
/*
 * Sonata peripheral subsystem top level.
 * Host req/gnt/rvalid port in front of the access sequencer,
 * which drives the GPIO, PWM and timer blocks.
 */
`timescale 1ns/1ps

`include "periph_consts.svh"

module sonata_periph (
  input  logic                      clk_sys_i,
  input  logic                      rst_n_i,

  // Host port.
  input  logic                      req_i,
  input  logic                      we_i,
  input  logic [`PERIPH_ADDR_W-1:0] addr_i,
  input  logic [`PERIPH_BE_W-1:0]   be_i,
  input  logic [`PERIPH_DATA_W-1:0] wdata_i,
  output logic                      gnt_o,
  output logic                      rvalid_o,
  output logic [`PERIPH_DATA_W-1:0] rdata_o,
  output logic                      err_o,

  // Pins.
  input  logic [`GPI_W-1:0]         gp_i,
  output logic [`GPO_W-1:0]         gp_o,
  output logic [`PWM_CH-1:0]        pwm_o,
  output logic                      timer_irq_o
);

  logic                      gpio_req;
  logic                      pwm_req;
  logic                      timer_req;
  logic                      dev_we;
  logic [`PERIPH_OFF_W-1:0]  dev_off;
  logic [`PERIPH_BE_W-1:0]   dev_be;
  logic [`PERIPH_DATA_W-1:0] dev_wdata;
  logic [`PERIPH_DATA_W-1:0] gpio_rdata;
  logic [`PERIPH_DATA_W-1:0] pwm_rdata;
  logic [`PERIPH_DATA_W-1:0] timer_rdata;

  bus_ctrl u_bus_ctrl (
    .clk_sys_i    (clk_sys_i),
    .rst_n_i      (rst_n_i),
    .req_i        (req_i),
    .we_i         (we_i),
    .addr_i       (addr_i),
    .be_i         (be_i),
    .wdata_i      (wdata_i),
    .gnt_o        (gnt_o),
    .rvalid_o     (rvalid_o),
    .rdata_o      (rdata_o),
    .err_o        (err_o),
    .gpio_req_o   (gpio_req),
    .pwm_req_o    (pwm_req),
    .timer_req_o  (timer_req),
    .dev_we_o     (dev_we),
    .dev_off_o    (dev_off),
    .dev_be_o     (dev_be),
    .dev_wdata_o  (dev_wdata),
    .gpio_rdata_i (gpio_rdata),
    .pwm_rdata_i  (pwm_rdata),
    .timer_rdata_i(timer_rdata)
  );

  gpio u_gpio (
    .clk_sys_i(clk_sys_i),
    .rst_n_i  (rst_n_i),
    .req_i    (gpio_req),
    .we_i     (dev_we),
    .off_i    (dev_off),
    .be_i     (dev_be),
    .wdata_i  (dev_wdata),
    .rdata_o  (gpio_rdata),
    .gp_i     (gp_i),
    .gp_o     (gp_o)
  );

  pwm_bank u_pwm (
    .clk_sys_i(clk_sys_i),
    .rst_n_i  (rst_n_i),
    .req_i    (pwm_req),
    .we_i     (dev_we),
    .off_i    (dev_off),
    .be_i     (dev_be),
    .wdata_i  (dev_wdata),
    .rdata_o  (pwm_rdata),
    .pwm_o    (pwm_o)
  );

  periph_timer u_timer (
    .clk_sys_i(clk_sys_i),
    .rst_n_i  (rst_n_i),
    .req_i    (timer_req),
    .we_i     (dev_we),
    .off_i    (dev_off),
    .be_i     (dev_be),
    .wdata_i  (dev_wdata),
    .rdata_o  (timer_rdata),
    .irq_o    (timer_irq_o)
  );

endmodule

// File: testbench/tb_sonata_periph.sv
/*
 * Testbench for the sonata_periph subsystem.
 * Directed tests over the host port: reset state, GPIO, response
 * timing, unmapped accesses, PWM duty and the machine timer.
 */
`timescale 1ns/1ps

`include "periph_consts.svh"

module tb_sonata_periph;

  localparam int timeout_cycles = 1000;

  logic                      clk_sys;
  logic                      rst_n;
  logic                      req;
  logic                      we;
  logic [`PERIPH_ADDR_W-1:0] addr;
  logic [`PERIPH_BE_W-1:0]   be;
  logic [`PERIPH_DATA_W-1:0] wdata;
  logic                      gnt;
  logic                      rvalid;
  logic [`PERIPH_DATA_W-1:0] rdata;
  logic                      err;
  logic [`GPI_W-1:0]         gp_in;
  logic [`GPO_W-1:0]         gp_out;
  logic [`PWM_CH-1:0]        pwm;
  logic                      timer_irq;

  int          error_cnt;
  int          check_cnt;
  bit          timed_out;
  logic [15:0] lfsr_q;

  sonata_periph uut (
    .clk_sys_i  (clk_sys),
    .rst_n_i    (rst_n),
    .req_i      (req),
    .we_i       (we),
    .addr_i     (addr),
    .be_i       (be),
    .wdata_i    (wdata),
    .gnt_o      (gnt),
    .rvalid_o   (rvalid),
    .rdata_o    (rdata),
    .err_o      (err),
    .gp_i       (gp_in),
    .gp_o       (gp_out),
    .pwm_o      (pwm),
    .timer_irq_o(timer_irq)
  );

  always #50 clk_sys = ~clk_sys;

  ////////////////////////////////////////
  // Reporting and random bits
  ////////////////////////////////////////

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d, timeouts: %0d", check_cnt, error_cnt, timed_out);
    if (error_cnt == 0 && !timed_out) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    timed_out = 1'b1;
    $display("ERROR at %0t: timed out waiting for %s", $time, what);
    finish_run();
  endtask

  task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      error_cnt++;
      $display("MISMATCH at %0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
    end
  endtask

  // Galois LFSR, taps 16,14,13,11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  function automatic logic [`PERIPH_ADDR_W-1:0] reg_addr(
    input logic [`PERIPH_ADDR_W-1:0] base,
    input logic [`PERIPH_OFF_W-1:0]  off
  );
    return base + {4'b0000, off, 2'b00};
  endfunction

  ////////////////////////////////////////
  // Host bus tasks
  ////////////////////////////////////////

  task automatic wait_grant();
    int n;
    n = 0;
    @(negedge clk_sys);
    while (!gnt && n < timeout_cycles) begin
      @(negedge clk_sys);
      n++;
    end
    if (!gnt) report_timeout("grant");
  endtask

  // Edges from acceptance to the response beat. Grant stays low meanwhile.
  task automatic wait_response(output int lat);
    lat = 0;
    do begin
      @(negedge clk_sys);
      lat++;
      expect_eq("grant while busy", 32'(gnt), 32'd0);
    end while (!rvalid && lat < timeout_cycles);
    if (!rvalid) begin
      report_timeout("response");
    end else begin
      expect_eq("response latency", lat, 32'd2);
    end
  endtask

  task automatic bus_access(input logic w, input logic [`PERIPH_ADDR_W-1:0] a,
                            input logic [3:0] b, input logic [31:0] d,
                            output logic [31:0] rd, output logic er);
    int lat;
    @(posedge clk_sys);
    req   <= 1'b1;
    we    <= w;
    addr  <= a;
    be    <= b;
    wdata <= d;
    wait_grant();
    @(posedge clk_sys);
    req <= 1'b0;
    wait_response(lat);
    rd = rdata;
    er = err;
  endtask

  task automatic bus_write(input logic [`PERIPH_ADDR_W-1:0] a, input logic [3:0] b,
                           input logic [31:0] d, input logic exp_err);
    logic [31:0] rd;
    logic        er;
    bus_access(1'b1, a, b, d, rd, er);
    expect_eq("write error flag", 32'(er), 32'(exp_err));
    expect_eq("write response data", rd, 32'd0);
  endtask

  task automatic bus_read(input logic [`PERIPH_ADDR_W-1:0] a,
                          output logic [31:0] rd, output logic er);
    bus_access(1'b0, a, 4'hF, 32'd0, rd, er);
  endtask

  task automatic read_expect(input string what, input logic [`PERIPH_ADDR_W-1:0] a,
                             input logic [31:0] exp, input logic exp_err);
    logic [31:0] rd;
    logic        er;
    bus_read(a, rd, er);
    expect_eq({what, " data"}, rd, exp);
    expect_eq({what, " error flag"}, 32'(er), 32'(exp_err));
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic reset_state();
    @(negedge clk_sys);
    expect_eq("reset gnt", 32'(gnt), 32'd1);
    expect_eq("reset rvalid", 32'(rvalid), 32'd0);
    expect_eq("reset err", 32'(err), 32'd0);
    expect_eq("reset timer irq", 32'(timer_irq), 32'd0);
    expect_eq("reset gp_o", 32'(gp_out), 32'd0);
    expect_eq("reset pwm_o", 32'(pwm), 32'd0);
  endtask

  task automatic gpio_access();
    logic [31:0] rnd;
    bus_write(reg_addr(`GPIO_BASE, `GPIO_OUT_OFF), 4'hF, 32'h0000_00A5, 1'b0);
    expect_eq("gp_o after full write", 32'(gp_out), 32'h0000_00A5);
    read_expect("GPIO OUT", reg_addr(`GPIO_BASE, `GPIO_OUT_OFF), 32'h0000_00A5, 1'b0);
    // Byte 0 masked off, output holds.
    bus_write(reg_addr(`GPIO_BASE, `GPIO_OUT_OFF), 4'b1110, 32'hFFFF_FF5A, 1'b0);
    expect_eq("gp_o with byte 0 masked", 32'(gp_out), 32'h0000_00A5);
    bus_write(reg_addr(`GPIO_BASE, `GPIO_OUT_OFF), 4'b0001, 32'hFFFF_FF3C, 1'b0);
    expect_eq("gp_o with byte 0 only", 32'(gp_out), 32'h0000_003C);
    draw_bits(`GPI_W, rnd);
    @(posedge clk_sys);
    gp_in <= rnd[`GPI_W-1:0];
    repeat (4) @(posedge clk_sys);
    read_expect("GPIO IN", reg_addr(`GPIO_BASE, `GPIO_IN_OFF), rnd, 1'b0);
  endtask

  // Write, then a read held asserted across the busy period.
  task automatic response_timing();
    int lat;
    @(posedge clk_sys);
    req   <= 1'b1;
    we    <= 1'b1;
    addr  <= reg_addr(`GPIO_BASE, `GPIO_OUT_OFF);
    be    <= 4'hF;
    wdata <= 32'h0000_0081;
    wait_grant();
    @(posedge clk_sys);
    we    <= 1'b0;
    wdata <= '0;
    wait_response(lat);
    expect_eq("first response error flag", 32'(err), 32'd0);
    wait_grant();
    @(posedge clk_sys);
    req <= 1'b0;
    wait_response(lat);
    expect_eq("held read data", rdata, 32'h0000_0081);
    expect_eq("held read error flag", 32'(err), 32'd0);
    expect_eq("gp_o after held pair", 32'(gp_out), 32'h0000_0081);
  endtask

  task automatic unmapped_access();
    bus_write(12'h300, 4'hF, 32'hFFFF_FFFF, 1'b1);
    // Bits 9..8 are zero here, so a bad decode would hit GPIO OUT.
    bus_write(12'h800, 4'hF, 32'h0000_0055, 1'b1);
    read_expect("unmapped 0x300", 12'h300, 32'd0, 1'b1);
    read_expect("unmapped 0x800", 12'h800, 32'd0, 1'b1);
    expect_eq("gp_o after unmapped writes", 32'(gp_out), 32'h0000_0081);
    read_expect("GPIO OUT after unmapped", reg_addr(`GPIO_BASE, `GPIO_OUT_OFF),
                32'h0000_0081, 1'b0);
    read_expect("PWM duty 0 after unmapped", reg_addr(`PWM_BASE, 6'd0), 32'd0, 1'b0);
    // Timer is still disabled, so mtime holds its reset value.
    read_expect("timer mtime after unmapped", reg_addr(`TIMER_BASE, `TIMER_MTIME_OFF),
                32'd0, 1'b0);
  endtask

  task automatic pwm_duty_cycles();
    logic [31:0] rnd;
    logic [7:0]  duty [`PWM_CH];
    int          high_cnt [`PWM_CH];
    for (int n = 0; n < `PWM_CH; n++) begin
      draw_bits(`PWM_CTR_W, rnd);
      duty[n] = rnd[7:0];
      high_cnt[n] = 0;
    end
    // Last channel stays at zero duty.
    duty[`PWM_CH-1] = 8'h00;
    for (int n = 0; n < `PWM_CH; n++) begin
      bus_write(reg_addr(`PWM_BASE, `PERIPH_OFF_W'(n)), 4'hF, {24'h5A5A5A, duty[n]}, 1'b0);
    end
    for (int n = 0; n < `PWM_CH; n++) begin
      read_expect($sformatf("PWM duty %0d", n), reg_addr(`PWM_BASE, `PERIPH_OFF_W'(n)),
                  32'(duty[n]), 1'b0);
    end
    repeat (2) @(posedge clk_sys);
    // One full phase period.
    repeat (256) begin
      @(negedge clk_sys);
      for (int n = 0; n < `PWM_CH; n++) begin
        if (pwm[n]) high_cnt[n]++;
      end
    end
    for (int n = 0; n < `PWM_CH; n++) begin
      expect_eq($sformatf("PWM %0d high cycles", n), high_cnt[n], 32'(duty[n]));
    end
  endtask

  task automatic timer_interrupt();
    logic [31:0] rd;
    logic        er;
    int          n;
    bus_write(reg_addr(`TIMER_BASE, `TIMER_MTIME_OFF), 4'hF, 32'd0, 1'b0);
    bus_write(reg_addr(`TIMER_BASE, `TIMER_CMP_OFF), 4'hF, 32'd200, 1'b0);
    bus_write(reg_addr(`TIMER_BASE, `TIMER_CTRL_OFF), 4'hF, 32'd1, 1'b0);
    // Compare is 200 ticks out.
    for (n = 0; n < 100; n++) begin
      @(negedge clk_sys);
      expect_eq("timer irq before compare", 32'(timer_irq), 32'd0);
    end
    n = 0;
    while (!timer_irq && n < timeout_cycles) begin
      @(negedge clk_sys);
      n++;
    end
    if (!timer_irq) report_timeout("timer interrupt");
    bus_read(reg_addr(`TIMER_BASE, `TIMER_MTIME_OFF), rd, er);
    check_cnt++;
    if (rd < 32'd200) begin
      error_cnt++;
      $display("MISMATCH at %0t: mtime read 0x%08h is below compare 200", $time, rd);
    end
    expect_eq("mtime read error flag", 32'(er), 32'd0);
    expect_eq("timer irq held", 32'(timer_irq), 32'd1);
    bus_write(reg_addr(`TIMER_BASE, `TIMER_CTRL_OFF), 4'hF, 32'd0, 1'b0);
    expect_eq("timer irq after disable", 32'(timer_irq), 32'd0);
  endtask

  initial begin
    clk_sys   = 1'b0;
    rst_n     = 1'b0;
    req       = 1'b0;
    we        = 1'b0;
    addr      = '0;
    be        = '0;
    wdata     = '0;
    gp_in     = '0;
    error_cnt = 0;
    check_cnt = 0;
    timed_out = 1'b0;
    lfsr_q    = 16'd60;
    repeat (10) @(posedge clk_sys);
    rst_n <= 1'b1;
    reset_state();
    gpio_access();
    response_timing();
    unmapped_access();
    pwm_duty_cycles();
    timer_interrupt();
    finish_run();
  end

endmodule

// File: sonata_periph.f
+incdir+common
common/periph_pkg.sv
source/bus_ctrl.sv
source/gpio.sv
timer/periph_timer.sv
pwm/pwm_bank.sv
source/sonata_periph.sv
testbench/tb_sonata_periph.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the sonata_periph testbench with Verilator.
# Exit status is zero only when the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert \
  --top-module tb_sonata_periph \
  -f sonata_periph.f \
  --Mdir "$obj_dir" -o tb_sonata_periph \
  > "$build_log" 2>&1 \
  || { cat "$build_log"; echo "Verilator build failed"; exit 1; }

"./$obj_dir/tb_sonata_periph" > "$sim_log" 2>&1
cat "$sim_log"

grep -qx "TESTBENCH PASSED" "$sim_log" \
  && { echo "Simulation result: pass"; exit 0; } \
  || { echo "Simulation result: fail"; exit 1; }
